// File: run_sim.sh
#!/bin/sh
# Build and run the SRAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
      --top-module tb_sram -f vlog.f -o tb_sram; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sram > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^STATUS: PASS$" "$log"; then
   exit 0
fi

echo "Pass message not found in $log"
exit 1

// File: sram.sv
`timescale 1ns/10ps

module sram (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic                            req_i,
   input  logic                            we_i,
   input  logic [sram_pkg::ADDR_WIDTH-1:0] addr_i,
   input  logic [sram_pkg::BE_WIDTH-1:0]   be_i,
   input  logic [sram_pkg::DATA_WIDTH-1:0] wdata_i,
   input  sram_pkg::user_word_t            wuser_i,
   output logic [sram_pkg::DATA_WIDTH-1:0] rdata_o,
   output sram_pkg::user_word_t            ruser_o,
   output logic                            rvalid_o
);

   logic [sram_pkg::DATA_WIDTH-1:0] data_rd;  // Data bank read word
   sram_pkg::user_word_t            user_rd;  // User bank read word

   sram_bank #(
      .WIDTH (sram_pkg::DATA_WIDTH)
   ) i_data_bank (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .req_i    (req_i),
      .we_i     (we_i),
      .addr_i   (addr_i),
      .be_i     (be_i),
      .wdata_i  (wdata_i),
      .rdata_o  (data_rd)
   );

   // Sideband shares the low byte enables of the data word
   if (sram_pkg::USER_EN != 0) begin : gen_user_bank
      sram_bank #(
         .WIDTH (sram_pkg::USER_WIDTH)
      ) i_user_bank (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .req_i    (req_i),
         .we_i     (we_i),
         .addr_i   (addr_i),
         .be_i     (be_i[sram_pkg::USER_BE_WIDTH-1:0]),
         .wdata_i  (wuser_i),
         .rdata_o  (user_rd)
      );
   end else begin : gen_no_user_bank
      assign user_rd = '0;  // No store behind the sideband
   end

   sram_rd_merge i_rd_merge (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .req_i     (req_i),
      .we_i      (we_i),
      .data_rd_i (data_rd),
      .user_rd_i (user_rd),
      .rdata_o   (rdata_o),
      .ruser_o   (ruser_o),
      .rvalid_o  (rvalid_o)
   );

endmodule : sram

// File: sram_bank.sv
`timescale 1ns/10ps

module sram_bank #(
   parameter int unsigned WIDTH = sram_pkg::DATA_WIDTH  // Logical word width
) (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic                            req_i,
   input  logic                            we_i,
   input  logic [sram_pkg::ADDR_WIDTH-1:0] addr_i,
   input  logic [(WIDTH+7)/8-1:0]          be_i,
   input  logic [WIDTH-1:0]                wdata_i,
   output logic [WIDTH-1:0]                rdata_o
);

   // Geometry of this bank, rounded up to whole cuts
   localparam int unsigned BE_W     = (WIDTH + 7) / 8;
   localparam int unsigned NUM_CUTS = (WIDTH + sram_pkg::CUT_WIDTH - 1) / sram_pkg::CUT_WIDTH;
   localparam int unsigned WIDTH_ALIGNED    = NUM_CUTS * sram_pkg::CUT_WIDTH;
   localparam int unsigned BE_WIDTH_ALIGNED = NUM_CUTS * sram_pkg::CUT_BE_WIDTH;

   logic [WIDTH_ALIGNED-1:0]    wdata_aligned;  // Zero-padded write word
   logic [BE_WIDTH_ALIGNED-1:0] be_aligned;     // Padding lanes stay disabled
   logic [WIDTH_ALIGNED-1:0]    rdata_aligned;  // Cut read words side by side

   // Pad to cut alignment
   always_comb begin : p_align
      wdata_aligned            = '0;
      be_aligned               = '0;
      wdata_aligned[WIDTH-1:0] = wdata_i;
      be_aligned[BE_W-1:0]     = be_i;
   end

   // Padding bits of the top cut are dropped here
   assign rdata_o = rdata_aligned[WIDTH-1:0];

   // One cut per 64-bit slice
   for (genvar k = 0; k < NUM_CUTS; k++) begin : gen_cut
      sram_cut_if i_cut_if ();

      // Control is shared, payload and enables are sliced
      assign i_cut_if.req   = req_i;
      assign i_cut_if.we    = we_i;
      assign i_cut_if.addr  = addr_i;
      assign i_cut_if.be    = be_aligned[k*sram_pkg::CUT_BE_WIDTH +: sram_pkg::CUT_BE_WIDTH];
      assign i_cut_if.wdata = wdata_aligned[k*sram_pkg::CUT_WIDTH +: sram_pkg::CUT_WIDTH];

      assign rdata_aligned[k*sram_pkg::CUT_WIDTH +: sram_pkg::CUT_WIDTH] = i_cut_if.rdata;

      sram_cut #(
         .word_t (sram_pkg::cut_word_t)
      ) i_cut (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .port_i   (i_cut_if)
      );
   end

   // A write with undefined lanes would corrupt bytes in every cut
   a_wr_be_known : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (req_i && we_i) |-> !$isunknown(be_i)
   ) else $error("sram_bank: byte enables unknown on write request");

endmodule : sram_bank

// File: sram_cut.sv
`timescale 1ns/10ps

module sram_cut #(
   parameter type word_t = sram_pkg::cut_word_t  // Payload held in one cut
) (
   input  logic       clk_i,
   input  logic       arst_n_i,
   sram_cut_if.cut_mp port_i
);

   localparam int unsigned NUM_BYTES = $bits(word_t) / 8;  // Byte lanes per word

   word_t mem_q [sram_pkg::NUM_WORDS];  // Array, undefined until written
   word_t rdata_q;                      // First read stage
   logic  wr_en;
   logic  rd_en;

   assign wr_en = port_i.req & port_i.we;
   assign rd_en = port_i.req & ~port_i.we;  // Writes leave read data alone

   // Byte-masked write, no reset on the storage
   always_ff @(posedge clk_i) begin : p_mem_write
      if (wr_en) begin
         for (int unsigned b = 0; b < NUM_BYTES; b++) begin
            if (port_i.be[b]) begin
               mem_q[port_i.addr][b*8 +: 8] <= port_i.wdata[b*8 +: 8];  // Enabled lane only
            end
         end
      end
   end

   // Registered read, holds until the next read
   always_ff @(posedge clk_i or negedge arst_n_i) begin : p_rd_stage
      if (!arst_n_i) begin
         rdata_q <= '0;
      end else if (rd_en) begin
         rdata_q <= mem_q[port_i.addr];
      end
   end

   // Optional second stage for the slower macro timing
   if (sram_pkg::OUT_REGS != 0) begin : gen_out_reg
      word_t rdata_out_q;  // Follows rdata_q one cycle later

      always_ff @(posedge clk_i or negedge arst_n_i) begin : p_out_stage
         if (!arst_n_i) begin
            rdata_out_q <= '0;
         end else begin
            rdata_out_q <= rdata_q;  // Stage 1 holds, so stage 2 holds too
         end
      end

      assign port_i.rdata = rdata_out_q;
   end else begin : gen_no_out_reg
      assign port_i.rdata = rdata_q;  // Single-cycle latency
   end

   // The bank must present a clean address and direction with every strobe
   a_req_known : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      port_i.req |-> !$isunknown({port_i.addr, port_i.we})
   ) else $error("sram_cut: address or write enable unknown on request");

endmodule : sram_cut

// File: sram_cut_if.sv
`timescale 1ns/10ps

// Request and read-data bundle between a bank and one physical cut
interface sram_cut_if;

   logic                              req;    // Access strobe, one cycle
   logic                              we;     // 1 = write, 0 = read
   logic [sram_pkg::ADDR_WIDTH-1:0]   addr;
   logic [sram_pkg::CUT_BE_WIDTH-1:0] be;     // Byte lane enables
   sram_pkg::cut_word_t               wdata;
   sram_pkg::cut_word_t               rdata;  // Valid RD_LATENCY cycles after a read

   // Bank side drives the request
   modport bank_mp (
      output req,
      output we,
      output addr,
      output be,
      output wdata,
      input  rdata
   );

   // Cut side accepts every request, no handshake
   modport cut_mp (
      input  req,
      input  we,
      input  addr,
      input  be,
      input  wdata,
      output rdata
   );

endinterface : sram_cut_if

// File: sram_input.txt
# op addr be wdata wuser exp_data exp_user, all hex; op 0 idle, 1 write, 2 read
# exp_data and exp_user are compared on read lines only
1 00 fff 0123456789abcdef02468ace 5a 000000000000000000000000 00
1 01 fff fedcba9876543210deadbeef a5 000000000000000000000000 00
1 7f fff 111122223333444455556666 3c 000000000000000000000000 00
1 ff fff a5a5a5a55a5a5a5a0f0f0f0f c3 000000000000000000000000 00
2 00 000 000000000000000000000000 00 0123456789abcdef02468ace 5a
2 01 000 000000000000000000000000 00 fedcba9876543210deadbeef a5
0 00 000 000000000000000000000000 00 000000000000000000000000 00
2 7f 000 000000000000000000000000 00 111122223333444455556666 3c
2 ff 000 000000000000000000000000 00 a5a5a5a55a5a5a5a0f0f0f0f c3
1 10 fff 000000000000000000000000 11 000000000000000000000000 00
1 10 f00 cafef00d9999999999999999 22 000000000000000000000000 00
2 10 000 000000000000000000000000 00 cafef00d0000000000000000 11
1 10 003 777777777777777777771234 33 000000000000000000000000 00
2 10 000 000000000000000000000000 00 cafef00d0000000000001234 33
1 10 0a0 00000000ab00cd0000000000 44 000000000000000000000000 00
2 10 000 000000000000000000000000 00 cafef00dab00cd0000001234 33
1 20 fff 000000000000000000000000 7e 000000000000000000000000 00
1 20 ffe 111111111111111111111111 81 000000000000000000000000 00
2 20 000 000000000000000000000000 00 111111111111111111111100 7e
1 20 001 000000000000000000000099 81 000000000000000000000000 00
2 20 000 000000000000000000000000 00 111111111111111111111199 81
2 00 000 000000000000000000000000 00 0123456789abcdef02468ace 5a
2 01 000 000000000000000000000000 00 fedcba9876543210deadbeef a5
2 7f 000 000000000000000000000000 00 111122223333444455556666 3c
2 ff 000 000000000000000000000000 00 a5a5a5a55a5a5a5a0f0f0f0f c3
2 10 000 000000000000000000000000 00 cafef00dab00cd0000001234 33
1 30 fff 0f1e2d3c4b5a69788796a5b4 d2 000000000000000000000000 00
1 00 00f ffffffffffffffffffffffff 00 000000000000000000000000 00
2 20 000 000000000000000000000000 00 111111111111111111111199 81
2 30 000 000000000000000000000000 00 0f1e2d3c4b5a69788796a5b4 d2
2 00 000 000000000000000000000000 00 0123456789abcdefffffffff 00
0 00 000 000000000000000000000000 00 000000000000000000000000 00

// File: sram_pkg.sv
package sram_pkg;

   // Logical geometry of the macro
   localparam int unsigned DATA_WIDTH = 96;   // Data bits per word
   localparam int unsigned USER_WIDTH = 8;    // Sideband bits per word
   localparam int unsigned USER_EN    = 1;    // User store present
   localparam int unsigned NUM_WORDS  = 256;  // Depth
   localparam int unsigned ADDR_WIDTH = $clog2(NUM_WORDS);

   // One enable per data byte, rounded up
   localparam int unsigned BE_WIDTH      = (DATA_WIDTH + 7) / 8;
   localparam int unsigned USER_BE_WIDTH = (USER_WIDTH + 7) / 8;  // Low slice of be_i

   // Physical cut geometry
   localparam int unsigned CUT_WIDTH    = 64;
   localparam int unsigned CUT_BE_WIDTH = CUT_WIDTH / 8;  // 8 byte lanes per cut

   // Timing
   localparam int unsigned OUT_REGS   = 0;             // Extra output stage in every cut
   localparam int unsigned RD_LATENCY = 1 + OUT_REGS;  // Request to read data, in cycles

   // Payload word types
   typedef logic [CUT_WIDTH-1:0]  cut_word_t;
   typedef logic [USER_WIDTH-1:0] user_word_t;

endpackage : sram_pkg

// File: sram_rd_merge.sv
`timescale 1ns/10ps

module sram_rd_merge (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic                            req_i,
   input  logic                            we_i,
   input  logic [sram_pkg::DATA_WIDTH-1:0] data_rd_i,  // Trimmed data bank word
   input  sram_pkg::user_word_t            user_rd_i,  // Trimmed user bank word
   output logic [sram_pkg::DATA_WIDTH-1:0] rdata_o,
   output sram_pkg::user_word_t            ruser_o,
   output logic                            rvalid_o
);

   logic [sram_pkg::RD_LATENCY-1:0] rd_pipe_q;  // One stage per cycle of read latency
   logic                            rd_req;

   assign rd_req = req_i & ~we_i;  // Only reads produce a valid pulse

   // Strobe follows the data through the cut pipeline
   always_ff @(posedge clk_i or negedge arst_n_i) begin : p_rd_pipe
      if (!arst_n_i) begin
         rd_pipe_q <= '0;
      end else begin
         rd_pipe_q[0] <= rd_req;
         for (int i = 1; i < sram_pkg::RD_LATENCY; i++) begin
            rd_pipe_q[i] <= rd_pipe_q[i-1];  // Shift towards the output
         end
      end
   end

   assign rvalid_o = rd_pipe_q[sram_pkg::RD_LATENCY-1];

   // Cuts already hold the last read word
   assign rdata_o = data_rd_i;

   // No user store means a constant zero sideband
   assign ruser_o = (sram_pkg::USER_EN != 0) ? user_rd_i : '0;

   // Bank read words may only move on the cycle that rvalid_o marks
   a_rd_hold : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      !rvalid_o |-> $stable({data_rd_i, user_rd_i})
   ) else $error("sram_rd_merge: read data changed without rvalid");

endmodule : sram_rd_merge

// File: tb_sram.sv
`timescale 1ns/10ps

module tb_sram;

   // One line of sram_input.txt
   typedef struct packed {
      logic [3:0]                      op;        // 0 idle, 1 write, 2 read
      logic [sram_pkg::ADDR_WIDTH-1:0] addr;
      logic [sram_pkg::BE_WIDTH-1:0]   be;
      logic [sram_pkg::DATA_WIDTH-1:0] wdata;
      logic [sram_pkg::USER_WIDTH-1:0] wuser;
      logic [sram_pkg::DATA_WIDTH-1:0] exp_data;  // Read lines only
      logic [sram_pkg::USER_WIDTH-1:0] exp_user;
   } vec_t;

   // Read in flight
   typedef struct packed {
      logic [sram_pkg::ADDR_WIDTH-1:0] addr;
      logic [sram_pkg::DATA_WIDTH-1:0] data;
      logic [sram_pkg::USER_WIDTH-1:0] user;
      logic [31:0]                     cyc;   // Cycle count when driven
   } rd_exp_t;

   logic                            clk;
   logic                            arst_n;
   logic                            req;
   logic                            we;
   logic [sram_pkg::ADDR_WIDTH-1:0] addr;
   logic [sram_pkg::BE_WIDTH-1:0]   be;
   logic [sram_pkg::DATA_WIDTH-1:0] wdata;
   sram_pkg::user_word_t            wuser;
   logic [sram_pkg::DATA_WIDTH-1:0] rdata;
   sram_pkg::user_word_t            ruser;
   logic                            rvalid;

   vec_t    vec_q [$];  // Directed vectors
   rd_exp_t exp_q [$];  // Every read issued, oldest first
   int unsigned rd_idx = 0;  // Next read the monitor expects

   // Shadow memory, updated at issue time
   logic [sram_pkg::DATA_WIDTH-1:0] shadow_data [sram_pkg::NUM_WORDS];
   sram_pkg::user_word_t            shadow_user [sram_pkg::NUM_WORDS];
   bit                              shadow_init [sram_pkg::NUM_WORDS];  // Fully written once

   logic [sram_pkg::DATA_WIDTH-1:0] last_data = '0;  // Outputs must hold this between reads
   sram_pkg::user_word_t            last_user = '0;

   int unsigned n_random    = 200;
   int unsigned cycle_cnt   = 0;
   int unsigned cycle_limit = 100;  // Raised once the file is read
   int unsigned mon_pass    = 0;
   int unsigned mon_fail    = 0;
   int unsigned tb_pass     = 0;
   int unsigned tb_fail     = 0;

   sram i_sram (
      .clk_i    (clk),
      .arst_n_i (arst_n),
      .req_i    (req),
      .we_i     (we),
      .addr_i   (addr),
      .be_i     (be),
      .wdata_i  (wdata),
      .wuser_i  (wuser),
      .rdata_o  (rdata),
      .ruser_o  (ruser),
      .rvalid_o (rvalid)
   );

   initial begin : p_clk
      clk = 1'b0;
      forever #5 clk = ~clk;  // 10 ns period
   end

   // Cycle counter and run limit
   always @(posedge clk) begin : p_timeout
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // Outputs are stable at the falling edge
   always @(negedge clk) begin : p_monitor
      rd_exp_t head;
      if (arst_n) begin
         if (rvalid) begin
            assert (rd_idx < exp_q.size()) else begin
               mon_fail++;
               $display("rvalid_o was high at %0t with no read outstanding", $time);
            end
            if (rd_idx < exp_q.size()) begin
               head = exp_q[rd_idx];
               rd_idx++;
               assert (cycle_cnt - head.cyc == sram_pkg::RD_LATENCY) mon_pass++;
               else begin
                  mon_fail++;
                  $display("Read of address %h returned %0d cycles after its request at %0t",
                           head.addr, cycle_cnt - head.cyc, $time);
               end
               assert (rdata === head.data && ruser === head.user) mon_pass++;
               else begin
                  mon_fail++;
                  $display("Mismatch at %0t: addr %h expected %h/%h got %h/%h", $time,
                           head.addr, head.data, head.user, rdata, ruser);
               end
            end
            last_data = rdata;
            last_user = ruser;
         end else begin
            assert (rdata === last_data && ruser === last_user) else begin
               mon_fail++;
               $display("Mismatch at %0t: read outputs changed without rvalid_o, now %h/%h",
                        $time, rdata, ruser);
            end
            // Oldest read is due by now
            if (rd_idx < exp_q.size()) begin
               assert (cycle_cnt - exp_q[rd_idx].cyc < sram_pkg::RD_LATENCY) else begin
                  mon_fail++;
                  $display("Read of address %h never raised rvalid_o (at %0t)",
                           exp_q[rd_idx].addr, $time);
                  rd_idx++;
               end
            end
         end
      end
   end

   // Byte-enable write rule, user bytes follow the low enables
   task automatic shadow_write(input logic [sram_pkg::ADDR_WIDTH-1:0] a,
                               input logic [sram_pkg::BE_WIDTH-1:0] be_v,
                               input logic [sram_pkg::DATA_WIDTH-1:0] wd,
                               input sram_pkg::user_word_t wu);
      int k;
      for (k = 0; k < sram_pkg::BE_WIDTH; k++) begin
         if (be_v[k]) shadow_data[a][k*8 +: 8] = wd[k*8 +: 8];
      end
      for (k = 0; k < sram_pkg::USER_BE_WIDTH; k++) begin
         if (be_v[k]) shadow_user[a][k*8 +: 8] = wu[k*8 +: 8];
      end
      if (&be_v) shadow_init[a] = 1'b1;
   endtask

   // One access per falling edge
   task automatic drive_access(input logic [3:0] op,
                               input logic [sram_pkg::ADDR_WIDTH-1:0] a,
                               input logic [sram_pkg::BE_WIDTH-1:0] be_v,
                               input logic [sram_pkg::DATA_WIDTH-1:0] wd,
                               input sram_pkg::user_word_t wu,
                               input bit use_file,
                               input logic [sram_pkg::DATA_WIDTH-1:0] exp_d,
                               input sram_pkg::user_word_t exp_u);
      rd_exp_t entry;
      @(negedge clk);
      req   = (op != 4'd0);
      we    = (op == 4'd1);
      addr  = a;
      be    = be_v;
      wdata = wd;
      wuser = wu;
      if (op == 4'd1) begin
         shadow_write(a, be_v, wd, wu);
      end else if (op == 4'd2) begin
         entry.addr = a;
         entry.data = use_file ? exp_d : shadow_data[a];
         entry.user = use_file ? exp_u : shadow_user[a];
         if (sram_pkg::USER_EN == 0) entry.user = '0;  // Sideband reads as zero
         entry.cyc  = cycle_cnt;
         exp_q.push_back(entry);
      end
   endtask

   // Bus idle, then wait for every read to come back
   task automatic drain_reads();
      @(negedge clk);
      req = 1'b0;
      we  = 1'b0;
      while (rd_idx != exp_q.size()) @(negedge clk);
   endtask

   // Columns: op addr be wdata wuser exp_data exp_user, all hex
   task automatic load_vectors();
      int    fd;
      int    n;
      string line;
      vec_t  v;
      logic [3:0]                      op;
      logic [sram_pkg::ADDR_WIDTH-1:0] a;
      logic [sram_pkg::BE_WIDTH-1:0]   be_v;
      logic [sram_pkg::DATA_WIDTH-1:0] wd;
      logic [sram_pkg::USER_WIDTH-1:0] wu;
      logic [sram_pkg::DATA_WIDTH-1:0] ed;
      logic [sram_pkg::USER_WIDTH-1:0] eu;
      fd = $fopen("sram_input.txt", "r");
      if (fd == 0) begin
         tb_fail++;
         $display("Could not open sram_input.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h", op, a, be_v, wd, wu, ed, eu);
               if (n == 7) begin
                  v = '{op, a, be_v, wd, wu, ed, eu};
                  vec_q.push_back(v);
               end else begin
                  tb_fail++;
                  $display("Malformed line in sram_input.txt: %s", line);
               end
            end
         end
         $fclose(fd);
      end
      cycle_limit = (vec_q.size() + n_random) * 4 + 100;
   endtask

   // Small address pool so reads hit written words
   task automatic random_access();
      int unsigned                     pick;
      logic [31:0]                     rnd;
      logic [3:0]                      op;
      logic [sram_pkg::ADDR_WIDTH-1:0] a;
      logic [sram_pkg::BE_WIDTH-1:0]   be_v;
      logic [sram_pkg::DATA_WIDTH-1:0] wd;
      sram_pkg::user_word_t            wu;
      pick = $urandom % 8;
      rnd  = $urandom;
      a    = '0;
      a[3:0] = rnd[3:0];
      a[sram_pkg::ADDR_WIDTH-1] = 1'b1;
      rnd  = $urandom;
      be_v = rnd[sram_pkg::BE_WIDTH-1:0];
      wu   = rnd[31:32-sram_pkg::USER_WIDTH];
      wd   = {$urandom(), $urandom(), $urandom()};
      if (pick == 0) op = 4'd0;
      else if (pick < 4 || !shadow_init[a]) op = 4'd1;  // Unwritten word gets a write
      else op = 4'd2;
      if (!shadow_init[a]) be_v = '1;
      else if (be_v == '0) be_v[0] = 1'b1;
      drive_access(op, a, be_v, wd, wu, 1'b0, '0, '0);
   endtask

   task automatic report_test(input string name, input int unsigned pass_before,
                              input int unsigned fail_before);
      int unsigned passes;
      int unsigned fails;
      passes = mon_pass + tb_pass - pass_before;
      fails  = mon_fail + tb_fail - fail_before;
      $display("test %s: %0d checks passed, %0d failed", name, passes, fails);
   endtask

   initial begin : p_main
      int unsigned pass_mark;
      int unsigned fail_mark;
      void'($urandom(24522));
      arst_n = 1'b0;
      req    = 1'b0;
      we     = 1'b0;
      addr   = '0;
      be     = '0;
      wdata  = '0;
      wuser  = '0;
      load_vectors();
      repeat (4) @(negedge clk);
      arst_n = 1'b1;

      // Outputs clear before any read
      pass_mark = mon_pass + tb_pass;
      fail_mark = mon_fail + tb_fail;
      @(negedge clk);
      assert (rvalid === 1'b0 && rdata === '0 && ruser === '0) tb_pass++;
      else begin
         tb_fail++;
         $display("Mismatch at %0t: after reset got rvalid %b data %h user %h",
                  $time, rvalid, rdata, ruser);
      end
      report_test("reset_values", pass_mark, fail_mark);

      pass_mark = mon_pass + tb_pass;
      fail_mark = mon_fail + tb_fail;
      foreach (vec_q[i]) begin
         drive_access(vec_q[i].op, vec_q[i].addr, vec_q[i].be, vec_q[i].wdata,
                      vec_q[i].wuser, 1'b1, vec_q[i].exp_data, vec_q[i].exp_user);
      end
      drain_reads();
      report_test("directed_file", pass_mark, fail_mark);

      pass_mark = mon_pass + tb_pass;
      fail_mark = mon_fail + tb_fail;
      for (int unsigned i = 0; i < n_random; i++) begin
         random_access();
      end
      drain_reads();
      report_test("random_mix", pass_mark, fail_mark);

      $display("checks passed %0d, failed %0d", mon_pass + tb_pass, mon_fail + tb_fail);
      if (mon_fail + tb_fail == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule : tb_sram

// File: vlog.f
sram_pkg.sv
sram_cut_if.sv
sram_cut.sv
sram_bank.sv
sram_rd_merge.sv
sram.sv
tb_sram.sv
